//--- hw/data_router.sv
// Data port address decode, load return mux and simulation exit register
`timescale 1ns/1ps
`include "soc_defines.svh"

module data_router
  import soc_types_pkg::*;
  import soc_map_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,
  input  load_req_t                       load_req,
  input  store_req_t                      store_req,
  output load_rsp_t                       load_rsp,
  // RAM side
  input  xlen_t                           mem_rdata,
  output logic                            mem_we,
  output logic [`SOC_MEM_ADDR_WIDTH-4:0]  mem_waddr,
  output xlen_t                           mem_wdata,
  output logic [`SOC_XLEN/8-1:0]          mem_wmask,
  // UART side
  input  logic [7:0]                      uart_rdata,
  output logic                            uart_rd,
  output logic                            uart_wr,
  output logic [2:0]                      uart_idx,
  output logic [7:0]                      uart_wdata,
  // Simulation exit
  output logic                            exit,
  output xlen_t                           exit_code
);

  region_e load_region;
  region_e store_region;
  region_e load_region_q;
  logic    load_valid_q;

  function automatic region_e decode(xlen_t addr);
    if (addr >= `SOC_MEM_BASE && addr < `SOC_MEM_END) begin
      return REGION_MEM;
    end
    if (addr >= `SOC_UART_BASE && addr < `SOC_UART_END) begin
      return REGION_UART;
    end
    if (addr == `SOC_EXIT_ADDR) begin
      return REGION_EXIT;
    end
    return REGION_BAD;
  endfunction

  assign load_region  = decode(load_req.addr);
  assign store_region = decode(store_req.addr);

  // RAM write, stores elsewhere never reach it
  assign mem_we    = store_req.valid && store_region == REGION_MEM;
  assign mem_waddr = store_req.addr[`SOC_MEM_ADDR_WIDTH-1:3];
  assign mem_wdata = store_req.data;
  assign mem_wmask = store_req.mask;

  // UART strobes
  // The UART has one index, so a store to it takes the index when both
  // channels hit the UART in the same cycle
  assign uart_rd    = load_req.valid && load_region == REGION_UART;
  assign uart_wr    = store_req.valid && store_region == REGION_UART;
  assign uart_idx   = uart_wr ? store_req.addr[5:3] : load_req.addr[5:3];
  assign uart_wdata = store_req.data[7:0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      load_valid_q <= 1'b0;
    end else begin
      load_valid_q <= load_req.valid;
    end
  end

  always_ff @(posedge clk) begin
    load_region_q <= load_region;
  end

  // Return data of the region decoded one cycle earlier
  always_comb begin
    load_rsp.valid = load_valid_q;
    case (load_region_q)
      REGION_MEM:  load_rsp.data = mem_rdata;
      REGION_UART: load_rsp.data = xlen_t'(uart_rdata);
      default:     load_rsp.data = `SOC_BAD_DATA;
    endcase
  end

  // Sticky exit, the code of the first exit store is kept
  always_ff @(posedge clk) begin
    if (!rstn) begin
      exit      <= 1'b0;
      exit_code <= '0;
    end else if (store_req.valid && store_region == REGION_EXIT && !exit) begin
      exit      <= 1'b1;
      exit_code <= store_req.data;
    end
  end

endmodule

//--- hw/fetch_port.sv
// Instruction fetch port, one-cycle RAM read and 32-bit word select
`timescale 1ns/1ps
`include "soc_defines.svh"

module fetch_port
  import soc_types_pkg::*;
(
  input  logic                            clk,
  input  logic                            rstn,
  input  fetch_req_t                      fetch_req,
  output logic                            fetch_ready,
  output fetch_rsp_t                      fetch_rsp,
  // RAM read port
  output logic [`SOC_MEM_ADDR_WIDTH-4:0]  line_addr,
  input  xlen_t                           line
);

  logic accepted;
  logic rsp_valid_q;
  logic upper_q;

  assign accepted  = fetch_req.valid && fetch_ready;
  assign line_addr = fetch_req.addr[`SOC_MEM_ADDR_WIDTH-1:3];

  // Ready comes up one cycle after reset and never drops
  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch_ready <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      fetch_ready <= 1'b1;
      rsp_valid_q <= accepted;
    end
  end

  // Address bit 2 picks the upper half of the line
  always_ff @(posedge clk) begin
    if (accepted) begin
      upper_q <= fetch_req.addr[2];
    end
  end

  assign fetch_rsp.valid = rsp_valid_q;
  assign fetch_rsp.instr = upper_q ? line[63:32] : line[31:0];

endmodule

//--- hw/mem_system.sv
// Memory side of the SoC, RAM, UART and exit register behind fetch and data ports
`timescale 1ns/1ps
`include "soc_defines.svh"

module mem_system
  import soc_types_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // Instruction fetch
  input  fetch_req_t fetch_req,
  output logic       fetch_ready,
  output fetch_rsp_t fetch_rsp,
  // Data port
  input  load_req_t  load_req,
  output load_rsp_t  load_rsp,
  input  store_req_t store_req,
  // UART byte strobes
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  output logic       tx_valid,
  output logic [7:0] tx_data,
  // Simulation exit
  output logic       exit,
  output xlen_t      exit_code
);

  localparam int LINE_AW = `SOC_MEM_ADDR_WIDTH - 3;

  logic [LINE_AW-1:0]     fetch_line_addr;
  xlen_t                  fetch_line;
  xlen_t                  mem_rdata;
  logic                   mem_we;
  logic [LINE_AW-1:0]     mem_waddr;
  xlen_t                  mem_wdata;
  logic [`SOC_XLEN/8-1:0] mem_wmask;
  logic                   uart_rd;
  logic                   uart_wr;
  logic [2:0]             uart_idx;
  logic [7:0]             uart_wdata;
  logic [7:0]             uart_rdata;

  data_router u_router (
    .clk        (clk),
    .rstn       (rstn),
    .load_req   (load_req),
    .store_req  (store_req),
    .load_rsp   (load_rsp),
    .mem_rdata  (mem_rdata),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .uart_rdata (uart_rdata),
    .uart_rd    (uart_rd),
    .uart_wr    (uart_wr),
    .uart_idx   (uart_idx),
    .uart_wdata (uart_wdata),
    .exit       (exit),
    .exit_code  (exit_code)
  );

  uart8250 u_uart (
    .clk      (clk),
    .rstn     (rstn),
    .rd       (uart_rd),
    .wr       (uart_wr),
    .reg_idx  (uart_idx),
    .wdata    (uart_wdata),
    .rdata    (uart_rdata),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .tx_valid (tx_valid),
    .tx_data  (tx_data)
  );

  // Port 1 serves fetch, port 2 serves loads straight from the request
  sram2r1w #(
    .ADDR_WIDTH (LINE_AW),
    .DATA_WIDTH (`SOC_XLEN)
  ) u_ram (
    .clk    (clk),
    .raddr  (fetch_line_addr),
    .rdata  (fetch_line),
    .raddr2 (load_req.addr[`SOC_MEM_ADDR_WIDTH-1:3]),
    .rdata2 (mem_rdata),
    .we     (mem_we),
    .waddr  (mem_waddr),
    .wdata  (mem_wdata),
    .wmask  (mem_wmask)
  );

  fetch_port u_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .fetch_rsp   (fetch_rsp),
    .line_addr   (fetch_line_addr),
    .line        (fetch_line)
  );

endmodule

//--- hw/soc_defines.svh
// SoC memory map and width macros shared by the packages and the RTL
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Data and address width of the core side
`define SOC_XLEN 64

// Byte-address width of the RAM, 8192 lines of 64 bits
`define SOC_MEM_ADDR_WIDTH 16

// RAM region
`define SOC_MEM_BASE 64'h0000_0000_0000_0000
`define SOC_MEM_END  64'h0000_0000_0001_0000

// UART region, eight registers at 8-byte stride
`define SOC_UART_BASE 64'h0000_0000_1000_0000
`define SOC_UART_END  64'h0000_0000_1000_0040

// Simulation exit register
`define SOC_EXIT_ADDR 64'h0000_0000_2000_0000

// Load value returned from anything that is not RAM or UART
`define SOC_BAD_DATA 64'hbada_bada_bada_bada

`endif

//--- hw/soc_map_pkg.sv
// Address region and UART register offset encodings

package soc_map_pkg;

  // Target of a data access after address decode
  typedef enum logic [1:0] {
    REGION_MEM  = 2'd0,
    REGION_UART = 2'd1,
    REGION_EXIT = 2'd2,
    REGION_BAD  = 2'd3
  } region_e;

  // 8250 register offsets, word index inside the UART region
  // Offsets 0 and 1 map to DLL and DLM while LCR bit 7 is set
  typedef enum logic [2:0] {
    UART_RBR_THR = 3'd0,
    UART_IER     = 3'd1,
    UART_IIR_FCR = 3'd2,
    UART_LCR     = 3'd3,
    UART_MCR     = 3'd4,
    UART_LSR     = 3'd5,
    UART_MSR     = 3'd6,
    UART_SCR     = 3'd7
  } uart_reg_e;

endpackage

//--- hw/soc_types_pkg.sv
// Request and response types for the fetch, load and store channels
`include "soc_defines.svh"

package soc_types_pkg;

  typedef logic [`SOC_XLEN-1:0] xlen_t;

  // Instruction fetch request, byte address
  typedef struct packed {
    logic  valid;
    xlen_t addr;
  } fetch_req_t;

  // Instruction word returned one cycle after an accepted fetch
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic  valid;
    xlen_t addr;
  } load_req_t;

  typedef struct packed {
    logic  valid;
    xlen_t data;
  } load_rsp_t;

  // One mask bit per byte lane of data
  typedef struct packed {
    logic                    valid;
    xlen_t                   addr;
    xlen_t                   data;
    logic [`SOC_XLEN/8-1:0]  mask;
  } store_req_t;

endpackage

//--- hw/sram2r1w.sv
// Line RAM with two registered read ports and one byte-masked write port
`timescale 1ns/1ps

module sram2r1w #(
  parameter int ADDR_WIDTH = 13,
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  // Read port 1
  input  logic [ADDR_WIDTH-1:0]   raddr,
  output logic [DATA_WIDTH-1:0]   rdata,
  // Read port 2
  input  logic [ADDR_WIDTH-1:0]   raddr2,
  output logic [DATA_WIDTH-1:0]   rdata2,
  // Write port
  input  logic                    we,
  input  logic [ADDR_WIDTH-1:0]   waddr,
  input  logic [DATA_WIDTH-1:0]   wdata,
  input  logic [DATA_WIDTH/8-1:0] wmask
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam int NBYTES = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Reads sample the array before this edge's write lands
  always_ff @(posedge clk) begin
    rdata  <= mem[raddr];
    rdata2 <= mem[raddr2];
  end

  // Only the byte lanes with their mask bit set are updated
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wmask[b]) begin
          mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- hw/uart8250.sv
// 8250-compatible UART register file with transmit strobe and receive buffer
`timescale 1ns/1ps

module uart8250
  import soc_map_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // Register access
  input  logic       rd,
  input  logic       wr,
  input  logic [2:0] reg_idx,
  input  logic [7:0] wdata,
  output logic [7:0] rdata,
  // Receive byte strobe
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  // Transmit byte strobe
  output logic       tx_valid,
  output logic [7:0] tx_data
);

  logic [3:0] ier;
  logic [7:0] lcr;
  logic [4:0] mcr;
  logic [7:0] scr;
  logic [7:0] dll;
  logic [7:0] dlm;
  logic [7:0] rbr;
  logic       data_ready;
  logic       dlab;
  logic [7:0] lsr;
  logic [7:0] rd_mux;

  assign dlab = lcr[7];

  // THR empty and transmitter empty always set, data ready from RBR
  assign lsr = {1'b0, 1'b1, 1'b1, 4'b0000, data_ready};

  always_comb begin
    case (uart_reg_e'(reg_idx))
      UART_RBR_THR: rd_mux = dlab ? dll : rbr;
      UART_IER:     rd_mux = dlab ? dlm : {4'b0000, ier};
      // No interrupt pending
      UART_IIR_FCR: rd_mux = 8'h01;
      UART_LCR:     rd_mux = lcr;
      UART_MCR:     rd_mux = {3'b000, mcr};
      UART_LSR:     rd_mux = lsr;
      UART_MSR:     rd_mux = 8'h00;
      UART_SCR:     rd_mux = scr;
      default:      rd_mux = 8'h00;
    endcase
  end

  // Control registers
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ier <= '0;
      lcr <= '0;
      mcr <= '0;
    end else if (wr) begin
      case (uart_reg_e'(reg_idx))
        UART_IER: if (!dlab) ier <= wdata[3:0];
        UART_LCR: lcr <= wdata;
        UART_MCR: mcr <= wdata[4:0];
        default: ;
      endcase
    end
  end

  // Divisor latches and scratch
  always_ff @(posedge clk) begin
    if (wr && dlab && uart_reg_e'(reg_idx) == UART_RBR_THR) begin
      dll <= wdata;
    end
    if (wr && dlab && uart_reg_e'(reg_idx) == UART_IER) begin
      dlm <= wdata;
    end
    if (wr && uart_reg_e'(reg_idx) == UART_SCR) begin
      scr <= wdata;
    end
  end

  // Receive side; a new byte wins over a clearing read in the same cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      data_ready <= 1'b0;
    end else if (rx_valid) begin
      data_ready <= 1'b1;
    end else if (rd && !dlab && uart_reg_e'(reg_idx) == UART_RBR_THR) begin
      data_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rbr <= rx_data;
    end
  end

  // Read data follows rd by one cycle
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= rd_mux;
    end
  end

  // THR write with DLAB clear sends the byte out
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= wr && !dlab && uart_reg_e'(reg_idx) == UART_RBR_THR;
    end
  end

  always_ff @(posedge clk) begin
    tx_data <= wdata;
  end

endmodule

//--- sim.f
+incdir+hw
hw/soc_types_pkg.sv
hw/soc_map_pkg.sv
hw/sram2r1w.sv
hw/uart8250.sv
hw/data_router.sv
hw/fetch_port.sv
hw/mem_system.sv
testbench/tb_mem_system.sv

//--- testbench/tb_mem_system.sv
// Testbench for the SoC memory side with a reference model and concurrent output checks
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_mem_system
  import soc_types_pkg::*;
  import soc_map_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int WIN_LINES       = 64;
  localparam int RAND_CYCLES     = 400;
  // Upper bound on the directed UART, unmapped, exit and drain sequences
  localparam int DIRECTED_CYCLES = 80;
  localparam int MARGIN_CYCLES   = 50;
  // Window of preloaded RAM lines aligned so that bits 8..3 index the window
  localparam xlen_t WIN_BASE     = `SOC_MEM_BASE + 64'h4000;

  logic       clk;
  logic       rstn;
  fetch_req_t fetch_req;
  logic       fetch_ready;
  fetch_rsp_t fetch_rsp;
  load_req_t  load_req;
  load_rsp_t  load_rsp;
  store_req_t store_req;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       exit;
  xlen_t      exit_code;

  // Reference model state
  xlen_t      shadow [WIN_LINES];
  logic [7:0] lcr_m;
  logic [7:0] dll_m;
  logic [7:0] dlm_m;
  logic [7:0] scr_m;
  logic [7:0] rbr_m;
  logic [4:0] mcr_m;
  logic [3:0] ier_m;
  logic       dr_m;
  logic       exit_m;
  xlen_t      exit_code_m;

  // Expected outputs during the current cycle
  logic       exp_ready;
  fetch_rsp_t exp_fetch;
  load_rsp_t  exp_load;
  logic       exp_tx_valid;
  logic [7:0] exp_tx_data;
  logic       exp_exit;
  xlen_t      exp_exit_code;

  logic  check_en;
  string test_name;
  int    err_ready;
  int    err_fetch;
  int    err_load;
  int    err_tx;
  int    err_exit;

  mem_system u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .fetch_rsp   (fetch_rsp),
    .load_req    (load_req),
    .load_rsp    (load_rsp),
    .store_req   (store_req),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .exit        (exit),
    .exit_code   (exit_code)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  a_ready: assert property (@(posedge clk) disable iff (!check_en) fetch_ready == exp_ready)
    else begin
      err_ready++;
      $display("FAILED %s: fetch_ready expected %b actual %b", test_name, exp_ready,
               $sampled(fetch_ready));
    end

  a_fetch: assert property (@(posedge clk) disable iff (!check_en)
    fetch_rsp.valid == exp_fetch.valid && (!exp_fetch.valid || fetch_rsp.instr == exp_fetch.instr))
    else begin
      err_fetch++;
      $display("FAILED %s: fetch_rsp expected %h actual %h", test_name, exp_fetch,
               $sampled(fetch_rsp));
    end

  a_load: assert property (@(posedge clk) disable iff (!check_en)
    load_rsp.valid == exp_load.valid && (!exp_load.valid || load_rsp.data == exp_load.data))
    else begin
      err_load++;
      $display("FAILED %s: load_rsp expected %h actual %h", test_name, exp_load,
               $sampled(load_rsp));
    end

  a_tx: assert property (@(posedge clk) disable iff (!check_en)
    tx_valid == exp_tx_valid && (!exp_tx_valid || tx_data == exp_tx_data))
    else begin
      err_tx++;
      $display("FAILED %s: tx expected %b/%h actual %b/%h", test_name, exp_tx_valid,
               exp_tx_data, $sampled(tx_valid), $sampled(tx_data));
    end

  a_exit: assert property (@(posedge clk) disable iff (!check_en)
    exit == exp_exit && (!exp_exit || exit_code == exp_exit_code))
    else begin
      err_exit++;
      $display("FAILED %s: exit expected %b/%h actual %b/%h", test_name, exp_exit,
               exp_exit_code, $sampled(exit), $sampled(exit_code));
    end

  function automatic region_e region_of(xlen_t addr);
    if (addr >= `SOC_MEM_BASE && addr < `SOC_MEM_END) begin
      return REGION_MEM;
    end else if (addr >= `SOC_UART_BASE && addr < `SOC_UART_END) begin
      return REGION_UART;
    end else if (addr == `SOC_EXIT_ADDR) begin
      return REGION_EXIT;
    end
    return REGION_BAD;
  endfunction

  // Register value as an 8250 presents it with DLAB swapping in the divisor latches
  function automatic logic [7:0] uart_reg_value(logic [2:0] idx);
    case (uart_reg_e'(idx))
      UART_RBR_THR: return lcr_m[7] ? dll_m : rbr_m;
      UART_IER:     return lcr_m[7] ? dlm_m : {4'h0, ier_m};
      UART_IIR_FCR: return 8'h01;
      UART_LCR:     return lcr_m;
      UART_MCR:     return {3'b000, mcr_m};
      UART_LSR:     return {7'b0110_000, dr_m};
      UART_SCR:     return scr_m;
      default:      return 8'h00;
    endcase
  endfunction

  function automatic xlen_t load_value(xlen_t addr);
    case (region_of(addr))
      REGION_MEM:  return shadow[addr[8:3]];
      REGION_UART: return xlen_t'(uart_reg_value(addr[5:3]));
      default:     return `SOC_BAD_DATA;
    endcase
  endfunction

  // State changes at the edge that ends the current cycle
  function automatic void update_model();
    logic [2:0] sidx;
    sidx = store_req.addr[5:3];
    if (load_req.valid && region_of(load_req.addr) == REGION_UART &&
        load_req.addr[5:3] == 3'd0 && !lcr_m[7]) begin
      dr_m = 1'b0;
    end
    if (rx_valid) begin
      dr_m  = 1'b1;
      rbr_m = rx_data;
    end
    if (store_req.valid) begin
      case (region_of(store_req.addr))
        REGION_MEM: begin
          for (int b = 0; b < 8; b++) begin
            if (store_req.mask[b]) begin
              shadow[store_req.addr[8:3]][b*8 +: 8] = store_req.data[b*8 +: 8];
            end
          end
        end
        REGION_UART: begin
          case (uart_reg_e'(sidx))
            UART_RBR_THR: if (lcr_m[7]) dll_m = store_req.data[7:0];
            UART_IER: begin
              if (lcr_m[7]) dlm_m = store_req.data[7:0];
              else ier_m = store_req.data[3:0];
            end
            UART_LCR: lcr_m = store_req.data[7:0];
            UART_MCR: mcr_m = store_req.data[4:0];
            UART_SCR: scr_m = store_req.data[7:0];
            default: ;
          endcase
        end
        REGION_EXIT: begin
          if (!exit_m) begin
            exit_m      = 1'b1;
            exit_code_m = store_req.data;
          end
        end
        default: ;
      endcase
    end
  endfunction

  // Predicts the next cycle's outputs, waits for the falling edge, then idles the inputs
  task automatic next_cycle();
    fetch_rsp_t nx_fetch;
    load_rsp_t  nx_load;
    logic       nx_tx_valid;
    logic       nx_ready;
    xlen_t      fline;
    nx_ready       = rstn;
    nx_load.valid  = rstn && load_req.valid;
    nx_load.data   = load_req.valid ? load_value(load_req.addr) : '0;
    fline          = shadow[fetch_req.addr[8:3]];
    nx_fetch.valid = fetch_req.valid && exp_ready;
    nx_fetch.instr = fetch_req.addr[2] ? fline[63:32] : fline[31:0];
    nx_tx_valid    = rstn && store_req.valid && region_of(store_req.addr) == REGION_UART &&
                     store_req.addr[5:3] == 3'd0 && !lcr_m[7];
    if (rstn) begin
      update_model();
    end
    @(negedge clk);
    exp_ready     = nx_ready;
    exp_load      = nx_load;
    exp_fetch     = nx_fetch;
    exp_tx_valid  = nx_tx_valid;
    exp_tx_data   = store_req.data[7:0];
    exp_exit      = exit_m;
    exp_exit_code = exit_code_m;
    fetch_req     = '0;
    load_req      = '0;
    store_req     = '0;
    rx_valid      = 1'b0;
  endtask

  function automatic xlen_t win_addr(int line);
    return WIN_BASE + xlen_t'(line) * 8;
  endfunction

  task automatic store_op(xlen_t addr, xlen_t data, logic [7:0] mask);
    store_req.valid = 1'b1;
    store_req.addr  = addr;
    store_req.data  = data;
    store_req.mask  = mask;
    next_cycle();
  endtask

  task automatic load_op(xlen_t addr);
    load_req.valid = 1'b1;
    load_req.addr  = addr;
    next_cycle();
  endtask

  task automatic uart_write(uart_reg_e r, logic [7:0] value);
    store_op(`SOC_UART_BASE + {r, 3'b000}, xlen_t'(value), 8'h01);
  endtask

  task automatic uart_load(uart_reg_e r);
    load_op(`SOC_UART_BASE + {r, 3'b000});
  endtask

  // Masked stores, streaming loads and fetches over the preloaded window
  task automatic random_traffic(int cycles);
    int line_s;
    for (int i = 0; i < cycles; i++) begin
      line_s = $urandom_range(WIN_LINES - 1);
      if ($urandom_range(1) == 1) begin
        store_req.valid = 1'b1;
        store_req.addr  = win_addr(line_s);
        store_req.data  = {$urandom, $urandom};
        store_req.mask  = 8'($urandom);
      end
      // A quarter of the loads target the line being stored
      if ($urandom_range(3) != 0) begin
        load_req.valid = 1'b1;
        load_req.addr  = ($urandom_range(3) == 0) ? win_addr(line_s) :
                         win_addr($urandom_range(WIN_LINES - 1));
      end
      if ($urandom_range(1) == 1) begin
        fetch_req.valid = 1'b1;
        fetch_req.addr  = win_addr($urandom_range(WIN_LINES - 1)) + 4 * $urandom_range(1);
      end
      next_cycle();
    end
  endtask

  initial begin
    int line_u;
    void'($urandom(32'h2b7d));
    clk           = 1'b0;
    rstn          = 1'b0;
    fetch_req     = '0;
    load_req      = '0;
    store_req     = '0;
    rx_valid      = 1'b0;
    rx_data       = '0;
    check_en      = 1'b0;
    exp_ready     = 1'b0;
    exp_fetch     = '0;
    exp_load      = '0;
    exp_tx_valid  = 1'b0;
    exp_tx_data   = '0;
    exp_exit      = 1'b0;
    exp_exit_code = '0;
    lcr_m         = '0;
    dll_m         = '0;
    dlm_m         = '0;
    scr_m         = '0;
    rbr_m         = '0;
    mcr_m         = '0;
    ier_m         = '0;
    dr_m          = 1'b0;
    exit_m        = 1'b0;
    exit_code_m   = '0;
    err_ready     = 0;
    err_fetch     = 0;
    err_load      = 0;
    err_tx        = 0;
    err_exit      = 0;
    test_name     = "reset";

    // Outputs are checked from the first edge that has seen reset
    @(negedge clk);
    check_en = 1'b1;
    // Requests during reset must produce no response and no transmit strobe
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      load_req.valid  = 1'b1;
      load_req.addr   = win_addr($urandom_range(WIN_LINES - 1));
      fetch_req.valid = 1'b1;
      fetch_req.addr  = win_addr($urandom_range(WIN_LINES - 1));
      uart_write(UART_RBR_THR, 8'($urandom));
    end
    rstn = 1'b1;
    // A fetch in the first cycle after reset meets a low fetch_ready
    fetch_req.valid = 1'b1;
    fetch_req.addr  = win_addr(0);
    next_cycle();

    test_name = "preload";
    for (int l = 0; l < WIN_LINES; l++) begin
      store_op(win_addr(l), {$urandom, $urandom}, 8'hff);
    end

    test_name = "ram_fetch";
    random_traffic(RAND_CYCLES);

    test_name = "uart_thr";
    uart_write(UART_RBR_THR, 8'h5a);
    uart_write(UART_RBR_THR, 8'hc3);
    test_name = "uart_scratch";
    uart_write(UART_SCR, 8'h96);
    uart_load(UART_SCR);
    test_name = "uart_dlab";
    uart_write(UART_LCR, 8'h83);
    uart_write(UART_RBR_THR, 8'h1b);
    uart_write(UART_IER, 8'h02);
    uart_load(UART_RBR_THR);
    uart_load(UART_IER);
    uart_write(UART_LCR, 8'h03);
    uart_load(UART_LCR);
    uart_write(UART_IER, 8'h05);
    uart_load(UART_IER);
    uart_load(UART_IIR_FCR);
    test_name = "uart_rx";
    rx_valid = 1'b1;
    rx_data  = 8'($urandom);
    next_cycle();
    uart_load(UART_LSR);
    uart_load(UART_RBR_THR);
    uart_load(UART_LSR);

    test_name = "unmapped";
    load_op(`SOC_MEM_END);
    load_op(`SOC_UART_END);
    load_op(`SOC_EXIT_ADDR + 64'h8);
    load_op({$urandom, $urandom} | 64'h8000_0000_0000_0000);
    // These stores alias window lines in the low address bits
    for (int k = 0; k < 4; k++) begin
      line_u = $urandom_range(WIN_LINES - 1);
      store_op(`SOC_MEM_END + win_addr(line_u), {$urandom, $urandom}, 8'hff);
      load_op(win_addr(line_u));
    end

    test_name = "exit";
    store_op(`SOC_EXIT_ADDR, {$urandom, $urandom}, 8'hff);
    random_traffic(16);

    test_name = "drain";
    repeat (2) next_cycle();

    $display("Error counts: ready %0d, fetch %0d, load %0d, tx %0d, exit %0d",
             err_ready, err_fetch, err_load, err_tx, err_exit);
    if (err_ready + err_fetch + err_load + err_tx + err_exit == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + WIN_LINES + RAND_CYCLES + DIRECTED_CYCLES + MARGIN_CYCLES));
    $display("Timeout: the stimulus did not complete in the expected number of cycles");
    $display("Regression failed");
    $finish;
  end

endmodule
